// ==== rtl/rvCore_config.svh ====
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

// Address of the first instruction fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rtl/rvCore_pkg.sv ====
package rvCore_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		// Operand B straight through, for LUI
		aluPassB
	} aluOp_e;

	typedef enum logic [2:0] {
		bcNone,
		bcEq,
		bcNe,
		bcLt,
		bcGe,
		bcLtu,
		bcGeu
	} branchCond_e;

	typedef enum logic [1:0] {
		stFetch,
		stExecute,
		stMemAccess,
		stTrapped
	} seqState_e;

endpackage

// ==== rtl/control.sv ====
module control import rvCore_pkg::*; (
	input word_t instr,
	output aluOp_e aluOp,
	output logic aluSrcImm,
	output logic aluSrcPc,
	output word_t imm,
	output branchCond_e branchCond,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic isJal,
	output logic isJalr,
	output logic illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Format immediates, all sign extended from bit 31
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Shared funct3 to ALU op mapping for OP and OP-IMM
	function automatic aluOp_e funct3Op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: funct3Op = alt ? aluSub : aluAdd;
			3'b001: funct3Op = aluSll;
			3'b010: funct3Op = aluSlt;
			3'b011: funct3Op = aluSltu;
			3'b100: funct3Op = aluXor;
			3'b101: funct3Op = alt ? aluSra : aluSrl;
			3'b110: funct3Op = aluOr;
			default: funct3Op = aluAnd;
		endcase
	endfunction

	always_comb begin
		aluOp = aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		imm = immI;
		branchCond = bcNone;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		illegal = 1'b1;
		case (opcode)
			7'b0110011: begin
				// SUB and SRA are the only funct7 = 0100000 forms
				if (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					illegal = 1'b0;
					regWrite = 1'b1;
					aluOp = funct3Op(funct3, funct7[5]);
				end
			end
			7'b0010011: begin
				// Shift immediates carry funct7 in the upper imm bits
				if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0000000 ||
						(funct3 == 3'b101 && funct7 == 7'b0100000)) begin
					illegal = 1'b0;
					regWrite = 1'b1;
					aluSrcImm = 1'b1;
					aluOp = funct3Op(funct3, funct3 == 3'b101 && funct7[5]);
				end
			end
			7'b0110111: begin
				illegal = 1'b0;
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				imm = immU;
				aluOp = aluPassB;
			end
			7'b0010111: begin
				illegal = 1'b0;
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluSrcPc = 1'b1;
				imm = immU;
			end
			7'b0000011: begin
				if (funct3 == 3'b010) begin
					illegal = 1'b0;
					regWrite = 1'b1;
					memRead = 1'b1;
					memToReg = 1'b1;
					aluSrcImm = 1'b1;
				end
			end
			7'b0100011: begin
				if (funct3 == 3'b010) begin
					illegal = 1'b0;
					memWrite = 1'b1;
					aluSrcImm = 1'b1;
					imm = immS;
				end
			end
			7'b1101111: begin
				illegal = 1'b0;
				regWrite = 1'b1;
				isJal = 1'b1;
				imm = immJ;
			end
			7'b1100111: begin
				if (funct3 == 3'b000) begin
					illegal = 1'b0;
					regWrite = 1'b1;
					isJalr = 1'b1;
					aluSrcImm = 1'b1;
				end
			end
			7'b1100011: begin
				imm = immB;
				case (funct3)
					3'b000: branchCond = bcEq;
					3'b001: branchCond = bcNe;
					3'b100: branchCond = bcLt;
					3'b101: branchCond = bcGe;
					3'b110: branchCond = bcLtu;
					3'b111: branchCond = bcGeu;
					default: branchCond = bcNone;
				endcase
				illegal = (branchCond == bcNone);
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== rtl/aluUnit.sv ====
module aluUnit import rvCore_pkg::*; (
	input aluOp_e aluOp,
	input word_t opA,
	input word_t opB,
	input branchCond_e branchCond,
	output word_t aluResult,
	output logic condTrue
);

	logic [4:0] shamt;

	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: aluResult = {31'b0, opA < opB};
			aluSll: aluResult = opA << shamt;
			aluSrl: aluResult = opA >> shamt;
			aluSra: aluResult = word_t'($signed(opA) >>> shamt);
			aluPassB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// Branch compare on the raw register operands
	always_comb begin
		case (branchCond)
			bcEq: condTrue = (opA == opB);
			bcNe: condTrue = (opA != opB);
			bcLt: condTrue = ($signed(opA) < $signed(opB));
			bcGe: condTrue = ($signed(opA) >= $signed(opB));
			bcLtu: condTrue = (opA < opB);
			bcGeu: condTrue = (opA >= opB);
			default: condTrue = 1'b0;
		endcase
	end

endmodule

// ==== rtl/regFile.sv ====
module regFile import rvCore_pkg::*; (
	input logic clk,
	input logic rstN,
	input regAddr_t rs1Addr,
	input regAddr_t rs2Addr,
	input logic writeEn,
	input regAddr_t writeAddr,
	input word_t writeData,
	output word_t rs1Data,
	output word_t rs2Data
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
	assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// ==== rtl/coreSequencer.sv ====
`include "rvCore_config.svh"

module coreSequencer import rvCore_pkg::*; (
	input logic clk,
	input logic rstN,
	input word_t wbDatI,
	input logic wbAck,
	input word_t aluResult,
	input logic condTrue,
	input word_t imm,
	input word_t rs1Data,
	input word_t rs2Data,
	input logic aluSrcImm,
	input logic aluSrcPc,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input logic memToReg,
	input logic isJal,
	input logic isJalr,
	input branchCond_e branchCond,
	input logic illegal,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output word_t wbAdr,
	output word_t wbDatO,
	output word_t instr,
	output word_t pc,
	output word_t opA,
	output word_t opB,
	output logic writeEn,
	output regAddr_t writeAddr,
	output word_t writeData,
	output logic trap,
	output word_t trapPc
);

	seqState_e state;
	word_t pcPlus4;
	word_t pcPlusImm;
	word_t nextPc;
	logic branchTaken;
	logic isMem;
	logic ackSeen;

	assign wbStb = wbCyc;
	assign ackSeen = wbCyc && wbAck;
	assign isMem = memRead || memWrite;

	assign opA = aluSrcPc ? pc : rs1Data;
	assign opB = aluSrcImm ? imm : rs2Data;

	assign pcPlus4 = pc + 32'd4;
	assign pcPlusImm = pc + imm;
	assign branchTaken = (branchCond != bcNone) && condTrue;

	always_comb begin
		if (isJalr) begin
			nextPc = {aluResult[31:1], 1'b0};
		end else if (isJal || branchTaken) begin
			nextPc = pcPlusImm;
		end else begin
			nextPc = pcPlus4;
		end
	end

	// Loads write back on the data ack, everything else in execute
	assign writeAddr = instr[11:7];
	assign writeEn = (state == stExecute && regWrite && !memToReg) ||
		(state == stMemAccess && ackSeen && memToReg);
	assign writeData = (state == stMemAccess) ? wbDatI :
		(isJal || isJalr) ? pcPlus4 : aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stFetch;
			pc <= `RV_RESET_PC;
			instr <= '0;
			wbCyc <= 1'b0;
			wbWe <= 1'b0;
			trap <= 1'b0;
			trapPc <= '0;
		end else begin
			case (state)
				stFetch: begin
					if (!wbCyc) begin
						wbCyc <= 1'b1;
						wbWe <= 1'b0;
					end else if (wbAck) begin
						wbCyc <= 1'b0;
						instr <= wbDatI;
						state <= stExecute;
					end
				end
				stExecute: begin
					if (illegal) begin
						trap <= 1'b1;
						trapPc <= pc;
						state <= stTrapped;
					end else begin
						// Start the data access or the next fetch right away
						wbCyc <= 1'b1;
						wbWe <= memWrite;
						state <= isMem ? stMemAccess : stFetch;
						if (!memRead) begin
							pc <= nextPc;
						end
					end
				end
				stMemAccess: begin
					if (wbAck) begin
						wbCyc <= 1'b0;
						wbWe <= 1'b0;
						state <= stFetch;
						if (memRead) begin
							pc <= nextPc;
						end
					end
				end
				stTrapped: begin
					state <= stTrapped;
				end
			endcase
		end
	end

	// Bus address and write data
	always_ff @(posedge clk) begin
		if (state == stFetch && !wbCyc) begin
			wbAdr <= pc;
		end else if (state == stExecute && !illegal) begin
			wbAdr <= isMem ? aluResult : nextPc;
			wbDatO <= rs2Data;
		end
	end

endmodule

// ==== rtl/rvCore.sv ====
module rvCore import rvCore_pkg::*; (
	input logic clk,
	input logic rstN,
	input word_t wbDatI,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output word_t wbAdr,
	output word_t wbDatO,
	output logic trap,
	output word_t trapPc
);

	word_t instr;
	word_t pc;
	word_t imm;
	word_t opA;
	word_t opB;
	word_t aluResult;
	word_t rs1Data;
	word_t rs2Data;
	word_t writeData;
	regAddr_t writeAddr;
	aluOp_e aluOp;
	branchCond_e branchCond;
	logic aluSrcImm;
	logic aluSrcPc;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic isJal;
	logic isJalr;
	logic illegal;
	logic condTrue;
	logic writeEn;

	coreSequencer uSeq (
		.clk(clk),
		.rstN(rstN),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.aluResult(aluResult),
		.condTrue(condTrue),
		.imm(imm),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.aluSrcImm(aluSrcImm),
		.aluSrcPc(aluSrcPc),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.isJal(isJal),
		.isJalr(isJalr),
		.branchCond(branchCond),
		.illegal(illegal),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatO(wbDatO),
		.instr(instr),
		.pc(pc),
		.opA(opA),
		.opB(opB),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.trap(trap),
		.trapPc(trapPc)
	);

	control uControl (
		.instr(instr),
		.aluOp(aluOp),
		.aluSrcImm(aluSrcImm),
		.aluSrcPc(aluSrcPc),
		.imm(imm),
		.branchCond(branchCond),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.isJal(isJal),
		.isJalr(isJalr),
		.illegal(illegal)
	);

	aluUnit uAlu (
		.aluOp(aluOp),
		.opA(opA),
		.opB(opB),
		.branchCond(branchCond),
		.aluResult(aluResult),
		.condTrue(condTrue)
	);

	// Source fields come straight from the instruction register
	regFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.rs1Addr(instr[19:15]),
		.rs2Addr(instr[24:20]),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

endmodule

// ==== verif/wbMemModel.sv ====
module wbMemModel import rvCore_pkg::*; (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input word_t adr,
	input word_t datW,
	output word_t datR,
	output logic ack,
	input logic loadEn,
	input word_t loadAdr,
	input word_t loadData
);

	// 4 KiB, word addressed through adr[11:2]
	word_t mem [0:1023];
	logic [1:0] waitCnt;

	assign datR = mem[adr[11:2]];

	// Acknowledge after 0 to 3 wait cycles
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ack <= 1'b0;
			waitCnt <= 2'd0;
		end else if (ack) begin
			ack <= 1'b0;
			waitCnt <= 2'($urandom_range(3, 0));
		end else if (cyc && stb) begin
			if (waitCnt == 2'd0) begin
				ack <= 1'b1;
			end else begin
				waitCnt <= waitCnt - 2'd1;
			end
		end
	end

	// Backdoor load port shares the write path with the bus
	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAdr[11:2]] <= loadData;
		end else if (cyc && stb && we && !ack && waitCnt == 2'd0) begin
			mem[adr[11:2]] <= datW;
		end
	end

endmodule

// ==== verif/rvCore_sva.sv ====
module rvCore_sva import rvCore_pkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic wbAck,
	input word_t wbAdr,
	input word_t wbDatO,
	input logic trap
);

	stbInsideCyc: assert property (@(posedge clk) disable iff (!rstN)
		wbStb |-> wbCyc) else $error("wbStb high without wbCyc");

	// Request held until the slave answers
	requestStable: assert property (@(posedge clk) disable iff (!rstN)
		wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatO))
		else $error("bus request changed before wbAck");

	trapSticky: assert property (@(posedge clk) disable iff (!rstN)
		trap |=> trap) else $error("trap dropped without reset");

	idleAfterReset: assert property (@(posedge clk)
		$rose(rstN) |-> !wbCyc) else $error("wbCyc high in the first cycle after reset");

endmodule

bind rvCore rvCore_sva sva (
	.clk(clk),
	.rstN(rstN),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbWe(wbWe),
	.wbAck(wbAck),
	.wbAdr(wbAdr),
	.wbDatO(wbDatO),
	.trap(trap)
);

// ==== verif/rvCore_tb.sv ====
`include "rvCore_config.svh"

module rvCore_tb import rvCore_pkg::*; ();

	// Seven programs of under 2500 cycles each including loading
	localparam int cycleLimit = 20000;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic wbAck;
	logic trap;
	logic loadEn;
	word_t wbAdr;
	word_t wbDatO;
	word_t wbDatI;
	word_t trapPc;
	word_t loadAdr;
	word_t loadData;
	int cycles;
	int progLen;
	int testErr;
	int testsPassed;
	int testsFailed;
	string curTest;

	rvCore dut (
		.clk(clk),
		.rstN(rstN),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatO(wbDatO),
		.trap(trap),
		.trapPc(trapPc)
	);

	wbMemModel memModel (
		.clk(clk),
		.rstN(rstN),
		.cyc(wbCyc),
		.stb(wbStb),
		.we(wbWe),
		.adr(wbAdr),
		.datW(wbDatO),
		.datR(wbDatI),
		.ack(wbAck),
		.loadEn(loadEn),
		.loadAdr(loadAdr),
		.loadData(loadData)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the core never trapped within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	// Instruction encoders
	function automatic word_t rType(int f7, int rs2, int rs1, int f3, int rd);
		rType = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic word_t iType(int imm, int rs1, int f3, int rd, int op);
		iType = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t addiWord(int rd, int rs1, int imm);
		addiWord = iType(imm, rs1, 0, rd, 'h13);
	endfunction

	function automatic word_t lwWord(int rd, int imm, int rs1);
		lwWord = iType(imm, rs1, 2, rd, 'h03);
	endfunction

	function automatic word_t swWord(int rs2, int imm, int rs1);
		swWord = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic word_t bType(int f3, int rs1, int rs2, int imm);
		bType = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t uType(int imm20, int rd, int op);
		uType = {imm20[19:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t jalWord(int rd, int imm);
		jalWord = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic word_t fillWord(int addr);
		fillWord = word_t'(addr) * 32'h9E37_79B9 ^ 32'h5A5A_5A5A;
	endfunction

	// Reference shifts and compares built from unsigned arithmetic
	function automatic word_t powerOfTwo(int n);
		word_t p;
		p = 32'd1;
		for (int i = 0; i < n; i++) begin
			p = p * 32'd2;
		end
		powerOfTwo = p;
	endfunction

	function automatic word_t arithShiftRight(word_t v, int n);
		arithShiftRight = v[31] ? ~(~v / powerOfTwo(n)) : v / powerOfTwo(n);
	endfunction

	function automatic word_t lessSigned(word_t x, word_t y);
		lessSigned = (x[31] != y[31]) ? word_t'(x[31]) : word_t'(x < y);
	endfunction

	function automatic word_t memAt(int addr);
		word_t a;
		a = word_t'(addr);
		memAt = memModel.mem[a[11:2]];
	endfunction

	function automatic int here();
		here = `RV_RESET_PC + progLen * 4;
	endfunction

	task automatic poke(int addr, word_t w);
		@(posedge clk);
		loadEn <= 1'b1;
		loadAdr <= word_t'(addr);
		loadData <= w;
	endtask

	task automatic emit(word_t w);
		poke(here(), w);
		progLen++;
	endtask

	task automatic startTest(string name);
		curTest = name;
		testErr = 0;
		progLen = 0;
		for (int a = 'h400; a < 'h600; a += 4) begin
			poke(a, fillWord(a));
		end
	endtask

	task automatic checkEq(string what, word_t exp, word_t got);
		assert (got === exp) else begin
			$display("** Error %s: %s expected %h, actual %h", curTest, what, exp, got);
			testErr++;
		end
	endtask

	task automatic checkMem(int addr, word_t exp);
		checkEq($sformatf("mem[%h]", addr), exp, memAt(addr));
	endtask

	// Pulse reset, run until the trap, check where it stopped
	task automatic runProgram(int expTrapPc);
		@(posedge clk);
		loadEn <= 1'b0;
		rstN <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		while (!trap) @(negedge clk);
		checkEq("trapPc", word_t'(expTrapPc), trapPc);
	endtask

	task automatic busIdleAfterTrap();
		repeat (10) begin
			@(negedge clk);
			assert (!wbCyc) else begin
				$display("%s: a bus cycle started after the trap", curTest);
				testErr++;
			end
		end
	endtask

	task automatic endTest();
		if (testErr == 0) begin
			$display("%s passed", curTest);
			testsPassed++;
		end else begin
			$display("%s failed with %0d errors", curTest, testErr);
			testsFailed++;
		end
	endtask

	task automatic testRegAlu();
		int f7s [10] = '{0, 32, 0, 0, 0, 0, 0, 0, 0, 32};
		int f3s [10] = '{0, 0, 7, 6, 4, 2, 3, 1, 5, 5};
		word_t a;
		word_t b;
		word_t s;
		word_t expv [10];
		int sh;
		int endPc;
		a = -7;
		b = 5;
		// Shift amount 35 uses only its low five bits
		s = 35;
		sh = int'(s % 32);
		expv = '{a + b, a - b, a & b, a | b, a ^ b,
			lessSigned(a, b), word_t'(a < b),
			a * powerOfTwo(sh), a / powerOfTwo(sh), arithShiftRight(a, sh)};
		startTest("register ALU");
		emit(addiWord(1, 0, -7));
		emit(addiWord(2, 0, 5));
		emit(addiWord(3, 0, 35));
		for (int k = 0; k < 10; k++) begin
			emit(rType(f7s[k], (k >= 7) ? 3 : 2, 1, f3s[k], 10));
			emit(swWord(10, 'h400 + 4 * k, 0));
		end
		endPc = here();
		emit(32'h0);
		runProgram(endPc);
		for (int k = 0; k < 10; k++) begin
			checkMem('h400 + 4 * k, expv[k]);
		end
		endTest();
	endtask

	task automatic testImmediate();
		int f3s [9] = '{0, 7, 6, 4, 2, 3, 1, 5, 5};
		int imms [9] = '{-100, 'h7f0, 'h100, -1, -6, -1, 4, 4, 'h404};
		word_t a;
		word_t expv [9];
		int auipcPc;
		int endPc;
		a = -7;
		expv = '{a - 100, a & 32'h7f0, a | 32'h100, ~a, lessSigned(a, word_t'(-6)),
			word_t'(a < 32'hffff_ffff), a * powerOfTwo(4), a / powerOfTwo(4),
			arithShiftRight(a, 4)};
		startTest("immediate, LUI and AUIPC");
		emit(addiWord(1, 0, -7));
		for (int k = 0; k < 9; k++) begin
			emit(iType(imms[k], 1, f3s[k], 10, 'h13));
			emit(swWord(10, 'h400 + 4 * k, 0));
		end
		emit(uType('habcde, 5, 'h37));
		emit(swWord(5, 'h424, 0));
		auipcPc = here();
		emit(uType('h12345, 6, 'h17));
		emit(swWord(6, 'h428, 0));
		endPc = here();
		emit(32'h0);
		runProgram(endPc);
		for (int k = 0; k < 9; k++) begin
			checkMem('h400 + 4 * k, expv[k]);
		end
		checkMem('h424, 32'habcd_e000);
		checkMem('h428, word_t'(auipcPc) + 32'h1234_5000);
		endTest();
	endtask

	task automatic testBranches();
		// Even cases are taken and odd cases fall through
		int f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
		int r1s [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
		int r2s [12] = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};
		int endPc;
		startTest("branches");
		emit(addiWord(1, 0, -1));
		emit(addiWord(2, 0, 1));
		emit(addiWord(3, 0, 'h111));
		emit(addiWord(4, 0, 'h222));
		for (int k = 0; k < 12; k++) begin
			emit(bType(f3s[k], r1s[k], r2s[k], 12));
			emit(swWord(3, 'h400 + 4 * k, 0));
			emit(jalWord(0, 8));
			emit(swWord(4, 'h400 + 4 * k, 0));
		end
		endPc = here();
		emit(32'h0);
		runProgram(endPc);
		for (int k = 0; k < 12; k++) begin
			checkMem('h400 + 4 * k, (k % 2 == 0) ? 32'h222 : 32'h111);
		end
		endTest();
	endtask

	task automatic testJumps();
		int jalPc;
		int jalrPc;
		int endPc;
		startTest("JAL and JALR");
		jalPc = here();
		emit(jalWord(1, 12));
		emit(swWord(0, 'h404, 0));
		emit(swWord(0, 'h404, 0));
		emit(swWord(1, 'h400, 0));
		jalrPc = here() + 4;
		// Odd target lands on the store after the skipped one
		emit(addiWord(2, 0, jalrPc + 9));
		emit(iType(0, 2, 0, 3, 'h67));
		emit(swWord(0, 'h40c, 0));
		emit(swWord(3, 'h408, 0));
		endPc = here();
		emit(32'h0);
		runProgram(endPc);
		checkMem('h400, word_t'(jalPc + 4));
		checkMem('h408, word_t'(jalrPc + 4));
		checkMem('h404, fillWord('h404));
		checkMem('h40c, fillWord('h40c));
		endTest();
	endtask

	task automatic testLoadStore();
		word_t v0;
		word_t v1;
		word_t sum;
		int endPc;
		v0 = 32'h1234_5678;
		v1 = 32'h0fed_cba9;
		sum = v0 + v1 - 3;
		startTest("load and store");
		poke('h500, v0);
		poke('h504, v1);
		emit(lwWord(1, 'h500, 0));
		emit(lwWord(2, 'h504, 0));
		emit(rType(0, 2, 1, 0, 3));
		emit(addiWord(3, 3, -3));
		emit(swWord(3, 'h508, 0));
		emit(lwWord(4, 'h508, 0));
		emit(iType('h5a5, 4, 4, 5, 'h13));
		emit(swWord(5, 'h50c, 0));
		// x0 must stay zero after ALU and load writes
		emit(addiWord(0, 0, 123));
		emit(lwWord(0, 'h500, 0));
		emit(swWord(0, 'h510, 0));
		endPc = here();
		emit(32'h0);
		runProgram(endPc);
		checkMem('h500, v0);
		checkMem('h508, sum);
		checkMem('h50c, sum ^ 32'h5a5);
		checkMem('h510, 32'h0);
		endTest();
	endtask

	task automatic testIllegal();
		int badPc;
		startTest("illegal encodings");
		emit(addiWord(1, 0, 3));
		emit(swWord(1, 'h400, 0));
		badPc = here();
		// ADD with funct7 = 0000001
		emit(rType(1, 2, 1, 0, 3));
		emit(swWord(1, 'h404, 0));
		runProgram(badPc);
		checkMem('h400, 32'h3);
		checkMem('h404, fillWord('h404));
		busIdleAfterTrap();
		progLen = 0;
		emit(addiWord(1, 0, 5));
		badPc = here();
		// Opcode 1111011 is not RV32I
		emit(32'h0000_00fb);
		emit(swWord(1, 'h408, 0));
		runProgram(badPc);
		checkMem('h408, fillWord('h408));
		busIdleAfterTrap();
		endTest();
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		loadEn = 1'b0;
		loadAdr = '0;
		loadData = '0;
		cycles = 0;
		testsPassed = 0;
		testsFailed = 0;
		void'($urandom(60035));
		testRegAlu();
		testImmediate();
		testBranches();
		testJumps();
		testLoadStore();
		testIllegal();
		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== rvCore.f ====
+incdir+rtl
rtl/rvCore_pkg.sv
rtl/control.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/coreSequencer.sv
rtl/rvCore.sv
verif/wbMemModel.sv
verif/rvCore_sva.sv
verif/rvCore_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rvCore.f --top-module rvCore_tb

sim:
	verilator --binary --timing --assert -f rvCore.f --top-module rvCore_tb -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
